//--- src/menuPkg.sv
//////////////////////////////////////////////////////////////////////
// menu level types shared by the controller, sequencer and glyph ROM
//////////////////////////////////////////////////////////////////////

package menuPkg;

	// one entry per screen the panel can show
	typedef enum logic [3:0] {
		welcome,        // power-up greeting, times out to play
		play,
		record,
		delete,
		deleteAll,
		memFull,        // recorder full, times out to record
		message1,       // message screens stay contiguous
		message2,
		message3,
		message4,
		message5
	} screenT;

	// button press pulses, one clock wide each
	typedef struct packed {
		logic left;
		logic right;
		logic center;
		logic up;
		logic down;
	} buttonsT;

	// slot occupancy from the recorder
	// bit i is message i+1
	typedef logic [4:0] msgValidT;

endpackage

//--- src/lcdPkg.sv
//////////////////////////////////////////////////////////////////////
// character LCD bus types and fixed codes
//////////////////////////////////////////////////////////////////////

package lcdPkg;

	typedef logic [4:0] PosT; // character slot within one screen

	localparam PosT SetupCount = 5'd4; // command bytes ahead of the text

	// setup sequence sent before every screen
	localparam logic [7:0] CmdFunction = 8'h62; // function set byte as the panel expects
	localparam logic [7:0] CmdDisplay = 8'h0F;  // display on, cursor on, blink
	localparam logic [7:0] CmdClear = 8'h01;    // clear and home
	localparam logic [7:0] CmdEntry = 8'h06;    // increment, no shift

	// element 0 goes out first
	localparam logic [SetupCount-1:0][7:0] SetupCmds = {
		CmdEntry, CmdClear, CmdDisplay, CmdFunction
	};

	localparam logic [7:0] MarkerFull = 8'h2A;  // asterisk, slot has a recording
	localparam logic [7:0] MarkerEmpty = 8'hFC; // blank custom glyph

	// one byte on its way to the writer
	typedef struct packed {
		logic isCommand;      // rs low
		logic [7:0] dataByte;
		logic last;           // final byte of the screen
	} charReqT;

	// pins of the 4-bit HD44780 bus, en kept apart
	typedef struct packed {
		logic rw;
		logic rs;
		logic [3:0] data;
	} lcdBusT;

endpackage

//--- src/menuController.sv
`timescale 1ns/100ps

module menuController #(
	parameter int HoldCycles = 1000
) (
	input logic clkout,
	input logic reset,
	input menuPkg::buttonsT buttons,
	input logic memFull,            // status from the recorder, not the screen
	input logic drawDone,
	output menuPkg::screenT screen,
	output logic start
);
	import menuPkg::*;

	localparam int HoldW = $clog2(HoldCycles + 1);
	localparam logic [HoldW-1:0] HoldLast = HoldW'(HoldCycles - 1);

	logic [HoldW-1:0] holdCnt;  // idle cycles on a timed screen
	logic fromDelete;           // message browsing entered from delete
	logic booted;               // first cycle after reset seen
	logic evalEn;
	logic timeout;
	logic go;
	logic nextFromDelete;
	screenT nextScreen;

	// buttons only count once the screen is fully drawn
	assign evalEn = drawDone && !start && booted;
	assign timeout = (holdCnt == HoldLast);

	//////////////////////////////////////////////////////////////////////
	// menu rules, first match wins
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		nextScreen = screen;
		nextFromDelete = fromDelete;
		go = 1'b0;
		case (screen)
			welcome: begin
				if (buttons.right || timeout) begin
					nextScreen = play;
					go = 1'b1;
				end
			end
			play: begin
				if (buttons.up) begin
					nextScreen = record;
					go = 1'b1;
				end else if (buttons.center) begin
					nextScreen = message1;
					nextFromDelete = 1'b0; // left goes back to play
					go = 1'b1;
				end
			end
			record: begin
				go = 1'b1;
				if (buttons.up) nextScreen = delete;
				else if (buttons.down) nextScreen = play;
				else if (memFull) nextScreen = menuPkg::memFull; // port shadows the literal
				else if (buttons.left) nextScreen = record;      // redraw
				else go = 1'b0;
			end
			delete: begin
				go = 1'b1;
				if (buttons.up) nextScreen = deleteAll;
				else if (buttons.down) nextScreen = record;
				else if (buttons.center) begin
					nextScreen = message1;
					nextFromDelete = 1'b1;
				end else if (buttons.left) nextScreen = play;
				else go = 1'b0;
			end
			menuPkg::memFull: begin
				if (buttons.left || timeout) begin
					nextScreen = record;
					go = 1'b1;
				end
			end
			deleteAll: begin
				go = 1'b1;
				if (buttons.up) nextScreen = play;
				else if (buttons.center) nextScreen = deleteAll; // redraw
				else if (buttons.down) nextScreen = delete;
				else if (buttons.left) nextScreen = play;
				else go = 1'b0;
			end
			default: begin // message1 .. message5
				go = 1'b1;
				if (buttons.up)
					nextScreen = (screen == message5) ? message5 : screenT'(screen + 4'd1);
				else if (buttons.down)
					nextScreen = (screen == message1) ? message1 : screenT'(screen - 4'd1);
				else if (buttons.left)
					nextScreen = fromDelete ? delete : play;
				else go = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clkout) begin
		if (reset) begin
			screen <= welcome;
			start <= 1'b0;
			booted <= 1'b0;
			holdCnt <= '0;
			fromDelete <= 1'b0;
		end else begin
			booted <= 1'b1;
			start <= !booted || (evalEn && go); // first draw right after reset
			if (evalEn && go) begin
				screen <= nextScreen;
				fromDelete <= nextFromDelete;
				holdCnt <= '0;
			end else if (evalEn && (screen == welcome || screen == menuPkg::memFull)) begin
				holdCnt <= holdCnt + 1'b1; // counts idle time on timed screens
			end else if (!drawDone) begin
				holdCnt <= '0;
			end
		end
	end

	// a new screen is only requested once the previous one left the writer
	assert property (@(posedge clkout) disable iff (reset) start |-> drawDone)
		else $error("start raised while a screen is still being drawn");

endmodule

//--- src/screenSequencer.sv
`timescale 1ns/100ps

module screenSequencer (
	input logic clkout,
	input logic reset,
	input menuPkg::screenT screen,
	input logic start,
	input logic byteSent,
	output logic drawDone,
	output menuPkg::screenT reqScreen,
	output lcdPkg::PosT reqPos,
	output logic reqValid,
	input logic reqReady
);
	import menuPkg::*;
	import lcdPkg::*;

	PosT lastPos; // setup bytes plus text, minus one

	// number of text characters on each screen
	function automatic PosT textLen(input screenT s);
		PosT len;
		case (s)
			welcome: len = 5'd8;    // Welcome!
			play: len = 5'd5;       // trailing blank
			record: len = 5'd6;
			delete: len = 5'd6;
			deleteAll: len = 5'd10;
			memFull: len = 5'd11;
			default: len = 5'd9;    // marker, Message, digit
		endcase
		return len;
	endfunction

	assign lastPos = SetupCount + textLen(reqScreen) - 5'd1;

	//////////////////////////////////////////////////////////////////////
	// position walker
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clkout) begin
		if (reset) begin
			drawDone <= 1'b1;      // idle, nothing on its way
			reqValid <= 1'b0;
			reqPos <= '0;
			reqScreen <= welcome;
		end else begin
			if (reqValid && reqReady) begin
				if (reqPos == lastPos)
					reqValid <= 1'b0;  // all positions handed over
				else
					reqPos <= reqPos + 5'd1;
			end
			if (byteSent)
				drawDone <= 1'b1;    // last byte strobed out
			if (start) begin
				reqScreen <= screen; // latched for the whole draw
				reqPos <= '0;
				reqValid <= 1'b1;
				drawDone <= 1'b0;
			end
		end
	end

	// requests stop before the screen is reported done
	assert property (@(posedge clkout) disable iff (reset) drawDone |-> !reqValid)
		else $error("request pending while drawDone is high");

endmodule

//--- src/glyphRom.sv
`timescale 1ns/100ps

module glyphRom (
	input logic clkout,
	input logic reset,
	input menuPkg::screenT reqScreen,
	input lcdPkg::PosT reqPos,
	input logic reqValid,
	output logic reqReady,
	input menuPkg::msgValidT msgValid,
	output lcdPkg::charReqT charReq,
	output logic charValid,
	input logic charReady
);
	import menuPkg::*;
	import lcdPkg::*;

	//////////////////////////////////////////////////////////////////////
	// screen texts, first character in the top byte
	//////////////////////////////////////////////////////////////////////
	localparam logic [63:0] TxtWelcome = "Welcome!";
	localparam logic [39:0] TxtPlay = "Play ";
	localparam logic [47:0] TxtRecord = "Record";
	localparam logic [47:0] TxtDelete = "Delete";
	localparam logic [79:0] TxtDeleteAll = "Delete All";
	localparam logic [87:0] TxtMemFull = "Memory Full";
	localparam logic [55:0] TxtMessage = "Message";
	localparam int MsgLen = $bits(TxtMessage) / 8;

	// character idx of a right aligned text, with its last flag
	function automatic logic [8:0] pick(input logic [87:0] txt, input int len, input int idx);
		logic [7:0] ch;
		ch = txt[8*(len-1-idx) +: 8];
		return {ch, idx == len - 1};
	endfunction

	function automatic charReqT lookup(input screenT s, input PosT pos, input msgValidT mv);
		charReqT r;
		int idx;
		int slot;
		logic [8:0] txt;
		idx = int'(pos) - int'(SetupCount);
		slot = int'(s) - int'(message1); // message number minus one
		txt = '0;
		if (pos >= SetupCount) begin
			case (s)
				welcome: txt = pick(TxtWelcome, $bits(TxtWelcome) / 8, idx);
				play: txt = pick(TxtPlay, $bits(TxtPlay) / 8, idx);
				record: txt = pick(TxtRecord, $bits(TxtRecord) / 8, idx);
				delete: txt = pick(TxtDelete, $bits(TxtDelete) / 8, idx);
				deleteAll: txt = pick(TxtDeleteAll, $bits(TxtDeleteAll) / 8, idx);
				memFull: txt = pick(TxtMemFull, $bits(TxtMemFull) / 8, idx);
				default: begin
					if (idx == 0) begin
						txt = {mv[slot] ? MarkerFull : MarkerEmpty, 1'b0};
					end else if (idx == MsgLen + 1) begin
						txt = {8'h31 + 8'(slot), 1'b1}; // ascii digit closes the screen
					end else begin
						txt = pick(TxtMessage, MsgLen, idx - 1);
						txt[0] = 1'b0;
					end
				end
			endcase
		end
		r.isCommand = (pos < SetupCount);
		r.dataByte = r.isCommand ? SetupCmds[pos[1:0]] : txt[8:1];
		r.last = !r.isCommand && txt[0];
		return r;
	endfunction

	assign reqReady = !charValid || charReady; // output slot free or draining

	always_ff @(posedge clkout) begin
		if (reset)
			charValid <= 1'b0;
		else if (reqValid && reqReady)
			charValid <= 1'b1;
		else if (charReady)
			charValid <= 1'b0;
	end

	always_ff @(posedge clkout) begin
		if (reqValid && reqReady)
			charReq <= lookup(reqScreen, reqPos, msgValid); // held while stalled
	end

endmodule

//--- src/lcdWriter.sv
`timescale 1ns/100ps

module lcdWriter #(
	parameter int NibblePeriod = 4
) (
	input logic clkout,
	input logic reset,
	input lcdPkg::charReqT charReq,
	input logic charValid,
	output logic charReady,
	output logic byteSent,
	output lcdPkg::lcdBusT lcdBus,
	output logic en
);

	localparam int CntW = $clog2(NibblePeriod + 1);
	localparam logic [CntW-1:0] CntLast = CntW'(NibblePeriod - 1);

	lcdPkg::charReqT pend;  // byte on the bus
	logic busy;             // a nibble still waits for its strobe
	logic lowNib;           // 0 high nibble, 1 low nibble
	logic [CntW-1:0] cnt;   // hold cycles of the current nibble

	assign charReady = !busy; // may load during the final strobe

	// data and rs stay put through the en cycle
	assign lcdBus = '{
		rw: 1'b0,
		rs: !pend.isCommand,
		data: lowNib ? pend.dataByte[3:0] : pend.dataByte[7:4]
	};

	//////////////////////////////////////////////////////////////////////
	// nibble pacing and strobe
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clkout) begin
		if (reset) begin
			busy <= 1'b0;
			lowNib <= 1'b0;
			cnt <= '0;
			en <= 1'b0;
			byteSent <= 1'b0;
		end else begin
			en <= 1'b0;
			byteSent <= 1'b0;
			if (charValid && charReady) begin
				busy <= 1'b1;            // high nibble first
				lowNib <= 1'b0;
				cnt <= '0;
			end else if (busy) begin
				if (en) begin
					lowNib <= 1'b1;        // high strobe done, move on
					cnt <= '0;
				end else if (cnt == CntLast) begin
					en <= 1'b1;            // nibble held long enough
					if (lowNib) begin
						busy <= 1'b0;
						byteSent <= pend.last; // end of screen
					end
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clkout) begin
		if (charValid && charReady)
			pend <= charReq;
	end

	// single cycle strobes only
	assert property (@(posedge clkout) disable iff (reset) en |=> !en)
		else $error("en high for two cycles");

endmodule

//--- src/recorderLcd.sv
`timescale 1ns/100ps

module recorderLcd #(
	parameter int NibblePeriod = 4,
	parameter int HoldCycles = 1000
) (
	input logic clkout,
	input logic reset,
	input menuPkg::buttonsT buttons,
	input logic memFull,
	input menuPkg::msgValidT msgValid,
	output lcdPkg::lcdBusT lcdBus,
	output logic en
);

	menuPkg::screenT screen;     // chosen screen
	logic start;
	logic drawDone;
	menuPkg::screenT reqScreen;  // sequencer to ROM
	lcdPkg::PosT reqPos;
	logic reqValid;
	logic reqReady;
	lcdPkg::charReqT charReq;    // ROM to writer
	logic charValid;
	logic charReady;
	logic byteSent;

	//////////////////////////////////////////////////////////////////////
	// menu -> sequencer -> glyph ROM -> writer
	//////////////////////////////////////////////////////////////////////
	menuController #(.HoldCycles(HoldCycles)) menuCtrl (
		.clkout(clkout), .reset(reset), .buttons(buttons), .memFull(memFull),
		.drawDone(drawDone), .screen(screen), .start(start)
	);

	screenSequencer seqr (
		.clkout(clkout), .reset(reset), .screen(screen), .start(start),
		.byteSent(byteSent), .drawDone(drawDone), .reqScreen(reqScreen),
		.reqPos(reqPos), .reqValid(reqValid), .reqReady(reqReady)
	);

	glyphRom glyphs (
		.clkout(clkout), .reset(reset), .reqScreen(reqScreen), .reqPos(reqPos),
		.reqValid(reqValid), .reqReady(reqReady), .msgValid(msgValid),
		.charReq(charReq), .charValid(charValid), .charReady(charReady)
	);

	lcdWriter #(.NibblePeriod(NibblePeriod)) writer (
		.clkout(clkout), .reset(reset), .charReq(charReq), .charValid(charValid),
		.charReady(charReady), .byteSent(byteSent), .lcdBus(lcdBus), .en(en)
	);

endmodule

//--- tb/lcdCapture.sv
`timescale 1ns/100ps

module lcdCapture (
	input logic clkout,
	input logic reset,
	input lcdPkg::lcdBusT lcdBus,
	input logic en,
	output logic lowPhase,                 // next strobe carries the low nibble
	output int screenNum,                  // screens started so far
	output int byteCount,                  // bytes seen on the current screen
	output logic [8:0] screenBytes [0:31]  // rs and data per position
);

	logic [3:0] highNib;  // high nibble waiting for its partner
	logic highRs;
	logic [8:0] fullByte;

	assign fullByte = {highRs, highNib, lcdBus.data};

	//////////////////////////////////////////////////////////////////////
	// nibble pairing and screen framing
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clkout) begin
		if (reset) begin
			lowPhase <= 1'b0;
			screenNum <= 0;
			byteCount <= 0;
		end else if (en) begin
			lowPhase <= !lowPhase;
			if (!lowPhase) begin
				highNib <= lcdBus.data;      // first half of a byte
				highRs <= lcdBus.rs;
			end else if (fullByte == 9'h062) begin
				// function set command opens every screen
				screenNum <= screenNum + 1;
				byteCount <= 1;
				screenBytes[0] <= fullByte;
			end else begin
				if (byteCount < 32)
					screenBytes[byteCount[4:0]] <= fullByte;
				byteCount <= byteCount + 1;  // keeps counting past the buffer
			end
		end
	end

endmodule

//--- tb/recorderLcdTb.sv
`timescale 1ns/100ps

module recorderLcdTb;
	import menuPkg::*;
	import lcdPkg::*;

	localparam int NibblePeriod = 3;
	localparam int HoldCycles = 200;
	localparam int ScreenCount = 27;  // screens drawn by the stimulus
	localparam int TotalBytes = 309;  // setup plus text bytes of all of them
	localparam int WatchdogCycles = TotalBytes * 2 * (NibblePeriod + 1)
		+ 2 * HoldCycles + ScreenCount * 64 + 500;

	localparam buttonsT BtnNone = '0;
	localparam buttonsT BtnLeft = '{left: 1'b1, default: 1'b0};
	localparam buttonsT BtnRight = '{right: 1'b1, default: 1'b0};
	localparam buttonsT BtnCenter = '{center: 1'b1, default: 1'b0};
	localparam buttonsT BtnUp = '{up: 1'b1, default: 1'b0};
	localparam buttonsT BtnDown = '{down: 1'b1, default: 1'b0};

	typedef logic [0:15][7:0] byteListT; // one screen, position 0 first

	logic clkout = 1'b0;
	logic reset = 1'b1;
	buttonsT buttons = '0;
	logic memFullIn = 1'b0;
	msgValidT msgValid = '0;
	lcdBusT lcdBus;
	logic en;

	logic lowPhase;
	int capScreenNum;
	int capCount;
	logic [8:0] capBytes [0:31];

	screenT modelScreen = welcome;   // reference menu state
	logic modelFromDelete = 1'b0;
	screenT expScreens [0:63];       // expected screens in drawing order
	msgValidT expMv [0:63];          // slot pattern while each was drawn
	int expQueued = 0;
	int screensChecked = 0;
	int errorCount = 0;
	int seed;
	int sinceEn = 0;
	logic prevEn = 1'b0;

	recorderLcd #(.NibblePeriod(NibblePeriod), .HoldCycles(HoldCycles)) dut_i (
		.clkout(clkout), .reset(reset), .buttons(buttons), .memFull(memFullIn),
		.msgValid(msgValid), .lcdBus(lcdBus), .en(en)
	);

	lcdCapture lcdCap (
		.clkout(clkout), .reset(reset), .lcdBus(lcdBus), .en(en), .lowPhase(lowPhase),
		.screenNum(capScreenNum), .byteCount(capCount), .screenBytes(capBytes)
	);

	always #10 clkout = ~clkout; // 20 ns period

	//////////////////////////////////////////////////////////////////////
	// failure handling and compares
	//////////////////////////////////////////////////////////////////////
	task automatic abortRun();
		$display("TEST FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic compareByte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act) begin
			errorCount++;
			$display("** Error at %0.1f ns: %s expected 8'h%02h, got 8'h%02h",
				$realtime, name, exp, act);
			abortRun();
		end
	endtask

	task automatic compareBit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			errorCount++;
			$display("** Error at %0.1f ns: %s expected %b, got %b", $realtime, name, exp, act);
			abortRun();
		end
	endtask

	task automatic compareCount(input string name, input int exp, input int act);
		if (exp != act) begin
			errorCount++;
			$display("** Error at %0.1f ns: %s expected %0d, got %0d", $realtime, name, exp, act);
			abortRun();
		end
	endtask

	task automatic compareScreen(input string name, input screenT exp, input screenT act);
		if (exp !== act) begin
			errorCount++;
			$display("** Error at %0.1f ns: %s expected %s, got %s",
				$realtime, name, exp.name(), act.name());
			abortRun();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////
	function automatic string textOf(input screenT s);
		case (s)
			welcome: return "Welcome!";
			play: return "Play ";          // trailing blank is part of the text
			record: return "Record";
			delete: return "Delete";
			deleteAll: return "Delete All";
			memFull: return "Memory Full";
			default: return "Message";     // marker and digit added around it
		endcase
	endfunction

	function automatic int expectedLen(input screenT s);
		string txt;
		txt = textOf(s);
		if (s >= message1)
			return 4 + 1 + txt.len() + 1;
		return 4 + txt.len();
	endfunction

	function automatic byteListT expectedBytes(input screenT s, input msgValidT mv);
		byteListT list;
		string txt;
		int slot;
		list = '0;
		txt = textOf(s);
		list[0] = 8'h62;  // function set
		list[1] = 8'h0F;  // display, cursor, blink
		list[2] = 8'h01;  // clear
		list[3] = 8'h06;  // entry mode
		if (s >= message1) begin
			slot = int'(s) - int'(message1);
			list[4] = mv[slot] ? 8'h2A : 8'hFC; // asterisk or blank glyph
			for (int i = 0; i < txt.len(); i++)
				list[5 + i] = txt[i];
			list[12] = 8'h30 + 8'(slot + 1);    // message number digit
		end else begin
			for (int i = 0; i < txt.len(); i++)
				list[4 + i] = txt[i];
		end
		return list;
	endfunction

	// menu rule table, first match wins
	task automatic ruleStep(input buttonsT b, input logic mf, input logic timeout);
		screenT s;
		s = modelScreen;
		case (modelScreen)
			welcome: if (b.right || timeout) s = play;
			play: begin
				if (b.up) s = record;
				else if (b.center) begin
					s = message1;
					modelFromDelete = 1'b0;
				end
			end
			record: begin
				if (b.up) s = delete;
				else if (b.down) s = play;
				else if (mf) s = memFull;
				else if (b.left) s = record;
			end
			delete: begin
				if (b.up) s = deleteAll;
				else if (b.down) s = record;
				else if (b.center) begin
					s = message1;
					modelFromDelete = 1'b1;
				end else if (b.left) s = play;
			end
			memFull: if (b.left || timeout) s = record;
			deleteAll: begin
				if (b.up) s = play;
				else if (b.center) s = deleteAll;
				else if (b.down) s = delete;
				else if (b.left) s = play;
			end
			default: begin
				if (b.up) s = (modelScreen == message5) ? message5 : screenT'(modelScreen + 4'd1);
				else if (b.down) s = (modelScreen == message1) ? message1 : screenT'(modelScreen - 4'd1);
				else if (b.left) s = modelFromDelete ? delete : play;
			end
		endcase
		modelScreen = s;
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////
	task automatic expectScreen();
		expScreens[expQueued] = modelScreen;
		expMv[expQueued] = msgValid;
		expQueued++;
	endtask

	task automatic pressButtons(input buttonsT b, input logic mf);
		@(posedge clkout);
		#2;
		buttons = b;        // one cycle pulse
		memFullIn = mf;
		@(posedge clkout);
		#2;
		buttons = BtnNone;
		memFullIn = 1'b0;
	endtask

	task automatic waitChecked();
		while (screensChecked < expQueued)
			@(posedge clkout);
		repeat (20) @(posedge clkout); // idle so stray redraws would show up
	endtask

	task automatic step(input buttonsT b, input logic mf);
		ruleStep(b, mf, 1'b0);
		expectScreen();
		pressButtons(b, mf);
		waitChecked();
	endtask

	// press with no matching rule, no redraw may follow
	task automatic stayStep(input buttonsT b);
		ruleStep(b, 1'b0, 1'b0);
		pressButtons(b, 1'b0);
		repeat (100) @(posedge clkout);
		compareScreen("dut_i.screen", modelScreen, dut_i.screen);
	endtask

	task automatic holdStep();
		ruleStep(BtnNone, 1'b0, 1'b1); // no press, hold timer runs out
		expectScreen();
		waitChecked();
	endtask

	task automatic browseStep(input buttonsT b);
		@(posedge clkout);
		#2;
		msgValid = msgValidT'($random(seed)); // new slot pattern per message screen
		step(b, 1'b0);
	endtask

	task automatic noisyStep(input buttonsT b, input buttonsT noise, input logic mf);
		ruleStep(b, 1'b0, 1'b0);
		expectScreen();
		pressButtons(b, 1'b0);
		while (capScreenNum != expQueued || capCount < 3)
			@(posedge clkout);     // screen is mid draw
		pressButtons(noise, mf);  // not fed to the model
		waitChecked();
	endtask

	//////////////////////////////////////////////////////////////////////
	// screen compare process
	//////////////////////////////////////////////////////////////////////
	initial begin : compareScreens
		int len;
		byteListT exp;
		forever begin
			@(posedge clkout);
			if (capScreenNum > expQueued) begin
				$display("a screen started that the menu rules do not call for");
				abortRun();
			end
			if (screensChecked > 0 && capScreenNum == screensChecked)
				compareCount("bytes on the finished screen",
					expectedLen(expScreens[screensChecked - 1]), capCount);
			if (screensChecked < expQueued && capScreenNum == screensChecked + 1) begin
				len = expectedLen(expScreens[screensChecked]);
				if (capCount >= len) begin
					exp = expectedBytes(expScreens[screensChecked], expMv[screensChecked]);
					for (int i = 0; i < len; i++) begin
						compareBit($sformatf("lcdBus.rs of byte %0d, screen %0d", i, capScreenNum),
							i >= 4, capBytes[i][8]);
						compareByte($sformatf("lcdBus byte %0d, screen %0d", i, capScreenNum),
							exp[i], capBytes[i][7:0]);
					end
					compareScreen("dut_i.screen", expScreens[screensChecked], dut_i.screen);
					screensChecked++;
				end
			end
		end
	end

	// pin timing, rw low, single cycle en, fixed strobe spacing in a screen
	always @(posedge clkout) begin
		if (!reset) begin
			compareBit("lcdBus.rw", 1'b0, lcdBus.rw);
			if (prevEn)
				compareBit("en", 1'b0, en);
			sinceEn = sinceEn + 1;
			if (en) begin
				// high nibble of the function set starts a screen, no spacing rule
				if (lowPhase || lcdBus.rs || lcdBus.data != 4'h6)
					compareCount("en strobe spacing", NibblePeriod + 1, sinceEn);
				sinceEn = 0;
			end
			prevEn = en;
		end
	end

	initial begin : watchdog
		repeat (WatchdogCycles) @(posedge clkout);
		$display("watchdog expired after %0d cycles before all screens were drawn",
			WatchdogCycles);
		abortRun();
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////
	initial begin : stimulus
		seed = 32'h4e45_9f16;
		msgValid = msgValidT'($random(seed));
		expectScreen();                    // welcome right after reset
		repeat (8) @(posedge clkout);
		#2;
		reset = 1'b0;
		waitChecked();
		holdStep();                        // welcome times out to play

		step(BtnUp, 1'b0);                 // record
		step(BtnUp, 1'b0);                 // delete
		step(BtnUp, 1'b0);                 // delete all
		step(BtnDown, 1'b0);               // delete
		step(BtnDown, 1'b0);               // record
		step(BtnLeft, 1'b0);               // record redrawn

		step(BtnNone, 1'b1);               // memory full
		holdStep();                        // back to record
		step(BtnDown, 1'b0);               // play

		browseStep(BtnCenter);             // message 1 from play
		repeat (5) browseStep(BtnUp);      // up to 5, last one redraws
		step(BtnLeft, 1'b0);               // play
		step(BtnUp, 1'b0);
		step(BtnUp, 1'b0);                 // delete
		browseStep(BtnCenter);             // message 1 from delete
		browseStep(BtnUp);
		step(BtnLeft, 1'b0);               // returns to delete

		noisyStep(BtnUp, BtnDown, 1'b0);   // delete all, down while drawing
		noisyStep(BtnCenter, BtnLeft, 1'b0);
		noisyStep(BtnLeft, BtnUp, 1'b0);   // play
		noisyStep(BtnUp, BtnDown, 1'b1);   // record, memFull while drawing
		stayStep(BtnRight);                // no rule on record, must stay
		repeat (100) @(posedge clkout);

		compareCount("screens drawn", expQueued, capScreenNum);
		if (errorCount == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			abortRun();
		end
	end

endmodule

//--- sources.f
src/menuPkg.sv
src/lcdPkg.sv
src/menuController.sv
src/screenSequencer.sv
src/glyphRom.sv
src/lcdWriter.sv
src/recorderLcd.sv
tb/lcdCapture.sv
tb/recorderLcdTb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module recorderLcdTb -f sources.f \
	-o recorderLcdSim > run.log 2>&1 &&
	./obj_dir/recorderLcdSim >> run.log 2>&1
cat run.log
grep -qx "TEST OK" run.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
